// File: bank/flopMem.sv
/* single-port flop memory */
`timescale 1ns/100ps
`include "tbl_consts.svh"

// two-cycle read, address and data both registered
module flopMem (
    input  logic                            clockCore,
    input  logic                            enable,
    input  logic                            wr,
    input  logic [`TBL_ENTRY_BITS-1:0]      addr,
    input  logic [`TBL_DATA_BITS-1:0]       wrData,
    output logic [`TBL_DATA_BITS-1:0]       rdData
);

    logic [`TBL_DATA_BITS-1:0]      store [0:(1 << `TBL_ENTRY_BITS)-1];
    logic [`TBL_ENTRY_BITS-1:0]     rdAddrQ;

    // ======================================================================
    // write port
    // ======================================================================
    always_ff @(posedge clockCore) begin
        if (enable && wr) begin
            store[addr] <= wrData;
        end
    end

    // ======================================================================
    // read port
    // ======================================================================
    // first stage, hold address of last read
    always_ff @(posedge clockCore) begin
        if (enable && !wr) begin
            rdAddrQ <= addr;
        end
    end

    // second stage, array output flop
    // a write landing on the same edge is not seen here
    always_ff @(posedge clockCore) begin
        rdData <= store[rdAddrQ];
    end

endmodule

// File: bank/tableBank.sv
/* bank controller */
`timescale 1ns/100ps
`include "tbl_consts.svh"

// command stream has priority, cpu fills idle cycles
module tableBank (
    input  logic                            clockCore,
    input  logic                            resetCore,
    // command side
    input  logic                            ctrlMemReq,
    input  logic                            ctrlMemRd,
    input  logic [`TBL_ENTRY_BITS-1:0]      ctrlMemAddr,
    input  logic [`TBL_DATA_BITS-1:0]       ctrlMemWrData,
    output logic [`TBL_DATA_BITS-1:0]       ctrlMemRdData,
    // cpu side, level request
    input  logic                            cpuMemReq,
    input  logic                            cpuMemRd,
    input  logic [`TBL_ENTRY_BITS-1:0]      cpuMemAddr,
    input  logic [`TBL_DATA_BITS-1:0]       cpuMemWrData,
    output logic                            cpuMemAck,
    output logic [`TBL_DATA_BITS-1:0]       cpuMemRdData
);

    // cpu request tracking
    logic                           cpuReqD1;
    logic                           cpuReqD2;
    logic                           cpuRise;
    logic                           cpuPending;
    logic                           cpuAccept;
    logic                           cpuRdIssue;
    logic                           cpuWrIssue;
    logic                           cpuRdQ;
    logic [`TBL_ENTRY_BITS-1:0]     cpuAddrQ;
    logic [`TBL_DATA_BITS-1:0]      cpuWrDataQ;
    logic                           cpuWrDone;
    logic                           cpuRdD1;
    logic                           cpuRdD2;

    // command pipeline for forwarding
    logic                           ctrlReqF1;
    logic                           ctrlReqF2;
    logic                           ctrlRdF1;
    logic                           ctrlRdF2;
    logic [`TBL_ENTRY_BITS-1:0]     ctrlAddrF1;
    logic [`TBL_ENTRY_BITS-1:0]     ctrlAddrF2;
    logic [`TBL_DATA_BITS-1:0]      ctrlWrDataF1;
    logic                           fwdHit;

    // memory port
    logic                           memEnable;
    logic                           memWr;
    logic [`TBL_ENTRY_BITS-1:0]     memAddr;
    logic [`TBL_DATA_BITS-1:0]      memWrData;
    logic [`TBL_DATA_BITS-1:0]      memRdData;

    // ======================================================================
    // cpu request edge capture
    // ======================================================================
    always_ff @(posedge clockCore or negedge resetCore) begin
        if (!resetCore) begin
            cpuReqD1 <= 1'b0;
            cpuReqD2 <= 1'b0;
        end else begin
            cpuReqD1 <= cpuMemReq;
            cpuReqD2 <= cpuReqD1;
        end
    end

    // cpu holds these until ack
    always_ff @(posedge clockCore) begin
        cpuRdQ     <= cpuMemRd;
        cpuAddrQ   <= cpuMemAddr;
        cpuWrDataQ <= cpuMemWrData;
    end

    assign cpuRise = cpuReqD1 & ~cpuReqD2;

    // pending until an idle cycle
    always_ff @(posedge clockCore or negedge resetCore) begin
        if (!resetCore) begin
            cpuPending <= 1'b0;
        end else if (cpuAccept) begin
            cpuPending <= 1'b0;
        end else if (cpuRise) begin
            cpuPending <= 1'b1;
        end
    end

    // no command this cycle
    assign cpuAccept  = cpuPending & ~ctrlMemReq;
    assign cpuRdIssue = cpuAccept & cpuRdQ;
    assign cpuWrIssue = cpuAccept & ~cpuRdQ;

    // ======================================================================
    // memory arbitration
    // ======================================================================
    assign memEnable = ctrlMemReq | cpuAccept;
    assign memWr     = (ctrlMemReq & ~ctrlMemRd) | cpuWrIssue;
    assign memAddr   = ctrlMemReq ? ctrlMemAddr : cpuAddrQ;
    assign memWrData = ctrlMemReq ? ctrlMemWrData : cpuWrDataQ;

    flopMem mem (
        .clockCore (clockCore),
        .enable    (memEnable),
        .wr        (memWr),
        .addr      (memAddr),
        .wrData    (memWrData),
        .rdData    (memRdData)
    );

    // ======================================================================
    // command read path
    // ======================================================================
    always_ff @(posedge clockCore or negedge resetCore) begin
        if (!resetCore) begin
            ctrlReqF1 <= 1'b0;
            ctrlReqF2 <= 1'b0;
        end else begin
            ctrlReqF1 <= ctrlMemReq;
            ctrlReqF2 <= ctrlReqF1;
        end
    end

    always_ff @(posedge clockCore) begin
        ctrlRdF1     <= ctrlMemRd;
        ctrlRdF2     <= ctrlRdF1;
        ctrlAddrF1   <= ctrlMemAddr;
        ctrlAddrF2   <= ctrlAddrF1;
        ctrlWrDataF1 <= ctrlMemWrData;
    end

    // read then write to same entry on the next cycle
    // memory returns the old word, so take the write data instead
    assign fwdHit = ctrlReqF2 & ctrlRdF2 & ctrlReqF1 & ~ctrlRdF1
                  & (ctrlAddrF2 == ctrlAddrF1);

    assign ctrlMemRdData = fwdHit ? ctrlWrDataF1 : memRdData;

    // ======================================================================
    // cpu ack
    // ======================================================================
    always_ff @(posedge clockCore or negedge resetCore) begin
        if (!resetCore) begin
            cpuWrDone <= 1'b0;
            cpuRdD1   <= 1'b0;
            cpuRdD2   <= 1'b0;
            cpuMemAck <= 1'b0;
        end else begin
            cpuWrDone <= cpuWrIssue;
            cpuRdD1   <= cpuRdIssue;
            cpuRdD2   <= cpuRdD1;
            // write acks one cycle late, read two
            cpuMemAck <= cpuWrDone | cpuRdD2;
        end
    end

    // lines up with the read ack
    always_ff @(posedge clockCore) begin
        cpuMemRdData <= memRdData;
    end

endmodule

// File: common/tblPkg.sv
/* lookup table types */
`include "tbl_consts.svh"

package tblPkg;

    // field widths of the table address
    localparam int BANK_W  = `TBL_BANK_BITS;
    localparam int ENTRY_W = `TBL_ENTRY_BITS;
    localparam int ADDR_W  = BANK_W + ENTRY_W;

    // ======================================================================
    // table address, flat index or bank/entry split
    // ======================================================================
    // bank sits in the upper bits, entry in the lower bits
    typedef union packed {
        logic [ADDR_W-1:0] flat;
        struct packed {
            logic [BANK_W-1:0]  bank;
            logic [ENTRY_W-1:0] entry;
        } fields;
    } tblAddrU;

endpackage

// File: common/tbl_consts.svh
/* banked lookup table constants */
`ifndef TBL_CONSTS_SVH
`define TBL_CONSTS_SVH

// ==========================================================================
// table geometry
// ==========================================================================

// number of banks, one-hot request width
`define TBL_BANKS       4

// bank select field, upper bits of the table address
`define TBL_BANK_BITS   2

// entries per bank, as an address width
`define TBL_ENTRY_BITS  6

// stored word width
`define TBL_DATA_BITS   16

`endif

// File: design/cmdDispatch.sv
/* command and cpu dispatcher */
`timescale 1ns/100ps
`include "tbl_consts.svh"

module cmdDispatch (
    input  logic                                        clockCore,
    input  logic                                        resetCore,
    // command stream
    input  logic                                        cmdReq,
    input  logic                                        cmdRd,
    input  logic [tblPkg::ADDR_W-1:0]                   cmdAddr,
    input  logic [`TBL_DATA_BITS-1:0]                   cmdWrData,
    // cpu port
    input  logic                                        cpuReq,
    input  logic                                        cpuRd,
    input  logic [tblPkg::ADDR_W-1:0]                   cpuAddr,
    input  logic [`TBL_DATA_BITS-1:0]                   cpuWrData,
    // toward the banks
    output logic [`TBL_BANKS-1:0]                       bankCmdReq,
    output logic                                        bankCmdRd,
    output logic [`TBL_ENTRY_BITS-1:0]                  bankAddr,
    output logic [`TBL_DATA_BITS-1:0]                   bankWrData,
    output tblPkg::tblAddrU                             cmdBankSel,
    output logic [`TBL_BANKS-1:0]                       bankCpuReq,
    output logic                                        bankCpuRd,
    output logic [`TBL_ENTRY_BITS-1:0]                  bankCpuAddr,
    output logic [`TBL_DATA_BITS-1:0]                   bankCpuWrData
);

    logic                   cmdReqQ;
    logic                   cmdRdQ;
    tblPkg::tblAddrU        cmdAddrQ;
    logic [`TBL_DATA_BITS-1:0] cmdWrDataQ;
    logic                   cpuReqQ;
    logic                   cpuRdQ;
    tblPkg::tblAddrU        cpuAddrQ;
    logic [`TBL_DATA_BITS-1:0] cpuWrDataQ;

    // ======================================================================
    // input register stage
    // ======================================================================
    always_ff @(posedge clockCore or negedge resetCore) begin
        if (!resetCore) begin
            cmdReqQ <= 1'b0;
            cpuReqQ <= 1'b0;
        end else begin
            cmdReqQ <= cmdReq;
            cpuReqQ <= cpuReq;
        end
    end

    // payload, flat view in
    always_ff @(posedge clockCore) begin
        cmdRdQ        <= cmdRd;
        cmdAddrQ.flat <= cmdAddr;
        cmdWrDataQ    <= cmdWrData;
        cpuRdQ        <= cpuRd;
        cpuAddrQ.flat <= cpuAddr;
        cpuWrDataQ    <= cpuWrData;
    end

    // ======================================================================
    // bank decode
    // ======================================================================
    // one-hot strobe for commands, one-hot level for the cpu
    always_comb begin
        for (int b = 0; b < `TBL_BANKS; b++) begin
            bankCmdReq[b] = cmdReqQ && (int'(cmdAddrQ.fields.bank) == b);
            bankCpuReq[b] = cpuReqQ && (int'(cpuAddrQ.fields.bank) == b);
        end
    end

    // shared payload, entry view out
    assign bankCmdRd     = cmdRdQ;
    assign bankAddr      = cmdAddrQ.fields.entry;
    assign bankWrData    = cmdWrDataQ;
    assign bankCpuRd     = cpuRdQ;
    assign bankCpuAddr   = cpuAddrQ.fields.entry;
    assign bankCpuWrData = cpuWrDataQ;

    // collector needs the bank of each command
    assign cmdBankSel    = cmdAddrQ;

endmodule

// File: design/resultCollect.sv
/* result collector */
`timescale 1ns/100ps
`include "tbl_consts.svh"

module resultCollect (
    input  logic                                        clockCore,
    input  logic                                        resetCore,
    // dispatched command, one-hot per bank
    input  logic [`TBL_BANKS-1:0]                       cmdReq,
    input  logic                                        cmdRd,
    input  tblPkg::tblAddrU                             cmdBankSel,
    // per-bank results
    input  logic [`TBL_BANKS-1:0][`TBL_DATA_BITS-1:0]   bankCmdRdData,
    input  logic [`TBL_BANKS-1:0]                       bankCpuAck,
    input  logic [`TBL_BANKS-1:0][`TBL_DATA_BITS-1:0]   bankCpuRdData,
    // merged streams
    output logic [`TBL_DATA_BITS-1:0]                   cmdRdData,
    output logic                                        cmdRdValid,
    output logic                                        cpuAck,
    output logic [`TBL_DATA_BITS-1:0]                   cpuRdData
);

    logic                           rdStrobe;
    logic                           rdVldD1;
    logic                           rdVldD2;
    logic [tblPkg::BANK_W-1:0]      bankD1;
    logic [tblPkg::BANK_W-1:0]      bankD2;

    // ======================================================================
    // command read return
    // ======================================================================
    assign rdStrobe = (|cmdReq) & cmdRd;

    // follow the bank read latency
    always_ff @(posedge clockCore or negedge resetCore) begin
        if (!resetCore) begin
            rdVldD1    <= 1'b0;
            rdVldD2    <= 1'b0;
            cmdRdValid <= 1'b0;
        end else begin
            rdVldD1    <= rdStrobe;
            rdVldD2    <= rdVldD1;
            cmdRdValid <= rdVldD2;
        end
    end

    always_ff @(posedge clockCore) begin
        bankD1 <= cmdBankSel.fields.bank;
        bankD2 <= bankD1;
        // hold last word between reads
        if (rdVldD2) begin
            cmdRdData <= bankCmdRdData[bankD2];
        end
    end

    // ======================================================================
    // cpu ack merge
    // ======================================================================
    // one cpu request at a time, so at most one bank acks
    assign cpuAck = |bankCpuAck;

    always_comb begin
        cpuRdData = '0;
        for (int b = 0; b < `TBL_BANKS; b++) begin
            if (bankCpuAck[b]) begin
                cpuRdData = cpuRdData | bankCpuRdData[b];
            end
        end
    end

endmodule

// File: design/tableTop.sv
/* banked lookup table top */
`timescale 1ns/100ps
`include "tbl_consts.svh"

module tableTop (
    input  logic                            clockCore,
    input  logic                            resetCore,
    // command port
    input  logic                            cmdReq,
    input  logic                            cmdRd,
    input  logic [tblPkg::ADDR_W-1:0]       cmdAddr,
    input  logic [`TBL_DATA_BITS-1:0]       cmdWrData,
    output logic [`TBL_DATA_BITS-1:0]       cmdRdData,
    output logic                            cmdRdValid,
    // cpu port
    input  logic                            cpuReq,
    input  logic                            cpuRd,
    input  logic [tblPkg::ADDR_W-1:0]       cpuAddr,
    input  logic [`TBL_DATA_BITS-1:0]       cpuWrData,
    output logic                            cpuAck,
    output logic [`TBL_DATA_BITS-1:0]       cpuRdData
);

    // dispatcher to banks
    logic [`TBL_BANKS-1:0]                      bankCmdReq;
    logic                                       bankCmdRd;
    logic [`TBL_ENTRY_BITS-1:0]                 bankAddr;
    logic [`TBL_DATA_BITS-1:0]                  bankWrData;
    tblPkg::tblAddrU                            cmdBankSel;
    logic [`TBL_BANKS-1:0]                      bankCpuReq;
    logic                                       bankCpuRd;
    logic [`TBL_ENTRY_BITS-1:0]                 bankCpuAddr;
    logic [`TBL_DATA_BITS-1:0]                  bankCpuWrData;
    // banks to collector
    logic [`TBL_BANKS-1:0][`TBL_DATA_BITS-1:0]  bankCmdRdData;
    logic [`TBL_BANKS-1:0]                      bankCpuAck;
    logic [`TBL_BANKS-1:0][`TBL_DATA_BITS-1:0]  bankCpuRdData;

    cmdDispatch dispatch (
        .clockCore     (clockCore),
        .resetCore     (resetCore),
        .cmdReq        (cmdReq),
        .cmdRd         (cmdRd),
        .cmdAddr       (cmdAddr),
        .cmdWrData     (cmdWrData),
        .cpuReq        (cpuReq),
        .cpuRd         (cpuRd),
        .cpuAddr       (cpuAddr),
        .cpuWrData     (cpuWrData),
        .bankCmdReq    (bankCmdReq),
        .bankCmdRd     (bankCmdRd),
        .bankAddr      (bankAddr),
        .bankWrData    (bankWrData),
        .cmdBankSel    (cmdBankSel),
        .bankCpuReq    (bankCpuReq),
        .bankCpuRd     (bankCpuRd),
        .bankCpuAddr   (bankCpuAddr),
        .bankCpuWrData (bankCpuWrData)
    );

    // ======================================================================
    // one controller per bank
    // ======================================================================
    for (genvar b = 0; b < `TBL_BANKS; b++) begin : genBank
        tableBank bank (
            .clockCore     (clockCore),
            .resetCore     (resetCore),
            .ctrlMemReq    (bankCmdReq[b]),
            .ctrlMemRd     (bankCmdRd),
            .ctrlMemAddr   (bankAddr),
            .ctrlMemWrData (bankWrData),
            .ctrlMemRdData (bankCmdRdData[b]),
            .cpuMemReq     (bankCpuReq[b]),
            .cpuMemRd      (bankCpuRd),
            .cpuMemAddr    (bankCpuAddr),
            .cpuMemWrData  (bankCpuWrData),
            .cpuMemAck     (bankCpuAck[b]),
            .cpuMemRdData  (bankCpuRdData[b])
        );
    end

    resultCollect collect (
        .clockCore     (clockCore),
        .resetCore     (resetCore),
        .cmdReq        (bankCmdReq),
        .cmdRd         (bankCmdRd),
        .cmdBankSel    (cmdBankSel),
        .bankCmdRdData (bankCmdRdData),
        .bankCpuAck    (bankCpuAck),
        .bankCpuRdData (bankCpuRdData),
        .cmdRdData     (cmdRdData),
        .cmdRdValid    (cmdRdValid),
        .cpuAck        (cpuAck),
        .cpuRdData     (cpuRdData)
    );

endmodule

// File: flist.f
+incdir+common
common/tblPkg.sv
bank/flopMem.sv
bank/tableBank.sv
design/cmdDispatch.sv
design/resultCollect.sv
design/tableTop.sv
sim/tableTb.sv

// File: run.sh
#!/bin/sh
# build and run the lookup table testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -j 0 --timescale 1ns/100ps \
    --top-module tableTb -Mdir obj_dir -f flist.f
if [ $? -ne 0 ]; then
    echo "run.sh: verilator build failed"
    exit 1
fi

./obj_dir/VtableTb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "run.sh: simulation exited with status $status"
    exit 1
fi

if grep -q '^\*\*\* PASSED \*\*\*$' "$LOG"; then
    exit 0
else
    echo "run.sh: pass line not found in $LOG"
    exit 1
fi

// File: sim/tableTb.sv
/* lookup table testbench */
`timescale 1ns/100ps
`include "tbl_consts.svh"

module tableTb;

    // stimulus kinds
    localparam int kindCmdRd  = 0;
    localparam int kindCmdWr  = 1;
    localparam int kindCpuRd  = 2;
    localparam int kindCpuWr  = 3;
    localparam int kindPair   = 4;
    localparam int kindPend   = 5;
    localparam int kindDone   = 6;
    localparam int maxEntries = 512;

    logic                               clockCore = 1'b0;
    logic                               resetCore;
    logic                               cmdReq;
    logic                               cmdRd;
    logic [tblPkg::ADDR_W-1:0]          cmdAddr;
    logic [`TBL_DATA_BITS-1:0]          cmdWrData;
    logic [`TBL_DATA_BITS-1:0]          cmdRdData;
    logic                               cmdRdValid;
    logic                               cpuReq;
    logic                               cpuRd;
    logic [tblPkg::ADDR_W-1:0]          cpuAddr;
    logic [`TBL_DATA_BITS-1:0]          cpuWrData;
    logic                               cpuAck;
    logic [`TBL_DATA_BITS-1:0]          cpuRdData;

    // stimulus table and reference model
    string                              tName   [maxEntries];
    int                                 tKind   [maxEntries];
    logic [tblPkg::ADDR_W-1:0]          tAddr   [maxEntries];
    logic [`TBL_DATA_BITS-1:0]          tData   [maxEntries];
    logic [`TBL_DATA_BITS-1:0]          tExpect [maxEntries];
    logic [`TBL_DATA_BITS-1:0]          model   [1 << tblPkg::ADDR_W];
    int                                 nEntries;

    // command reads in flight, oldest first
    string                              expName [maxEntries];
    logic [`TBL_DATA_BITS-1:0]          expData [maxEntries];
    time                                expTime [maxEntries];
    time                                cmdLatency;
    int                                 nIssued;
    int                                 nChecked = 0;

    // last command drive on the port
    logic                               cmdDriven = 1'b0;
    time                                cmdDriveTime = 0;

    // the one cpu request in flight
    string                              cpuName;
    logic                               cpuExpRd;
    logic [`TBL_DATA_BITS-1:0]          cpuExpData;
    int                                 cpuStarts;
    int                                 cpuAcks = 0;
    logic                               ackLast = 1'b0;

    int                                 cmdErrors = 0;
    int                                 cpuErrors = 0;
    int                                 seqErrors;
    int                                 cycles = 0;
    int                                 cycleLimit = 0;

    tableTop dut (
        .clockCore  (clockCore),
        .resetCore  (resetCore),
        .cmdReq     (cmdReq),
        .cmdRd      (cmdRd),
        .cmdAddr    (cmdAddr),
        .cmdWrData  (cmdWrData),
        .cmdRdData  (cmdRdData),
        .cmdRdValid (cmdRdValid),
        .cpuReq     (cpuReq),
        .cpuRd      (cpuRd),
        .cpuAddr    (cpuAddr),
        .cpuWrData  (cpuWrData),
        .cpuAck     (cpuAck),
        .cpuRdData  (cpuRdData)
    );

    // 20 ns clock
    always #10 clockCore = ~clockCore;

    // run limit
    always @(posedge clockCore) begin
        cycles++;
        if (cycleLimit > 0 && cycles > cycleLimit) begin
            $display("timeout: run did not finish within %0d cycles", cycleLimit);
            $display("*** FAILED ***");
            $finish;
        end
    end

    // ======================================================================
    // table construction
    // ======================================================================
    // fill pattern covers every address bit
    function automatic logic [`TBL_DATA_BITS-1:0] fillWord(input int a);
        logic [7:0] lo;
        lo = 8'(a);
        return {lo, lo ^ 8'h5a};
    endfunction

    function automatic logic [`TBL_DATA_BITS-1:0] randWord();
        return `TBL_DATA_BITS'($urandom);
    endfunction

    task automatic addEntry(input string name, input int kind, input int bank, input int entry,
                            input logic [`TBL_DATA_BITS-1:0] data);
        tblPkg::tblAddrU a;
        a.fields.bank     = `TBL_BANK_BITS'(bank);
        a.fields.entry    = `TBL_ENTRY_BITS'(entry);
        tName[nEntries]   = name;
        tKind[nEntries]   = kind;
        tAddr[nEntries]   = a.flat;
        tData[nEntries]   = data;
        tExpect[nEntries] = '0;
        nEntries++;
    endtask

    task automatic buildTable();
        int b;
        int e;
        int r;
        for (int a = 0; a < (1 << tblPkg::ADDR_W); a++) begin
            addEntry("fill", kindCmdWr, a >> `TBL_ENTRY_BITS, a % 64, fillWord(a));
        end
        for (b = 0; b < `TBL_BANKS; b++) begin
            addEntry("cmdReadFill", kindCmdRd, b, 0, '0);
            addEntry("cmdReadFill", kindCmdRd, b, 63, '0);
            addEntry("cmdWrite", kindCmdWr, b, 5, randWord());
            addEntry("cmdReadBack", kindCmdRd, b, 5, '0);
            // read then write at once, read sees the new word
            addEntry("rdWrForward", kindPair, b, 9, randWord());
            addEntry("forwardKept", kindCmdRd, b, 9, '0);
        end
        // neighbour entry and neighbour bank must not forward
        addEntry("rdWrOtherEntry", kindCmdRd, 0, 10, '0);
        addEntry("rdWrOtherEntry", kindCmdWr, 0, 11, randWord());
        addEntry("rdWrOtherBank", kindCmdRd, 1, 10, '0);
        addEntry("rdWrOtherBank", kindCmdWr, 2, 10, randWord());
        // cpu range is entry 48 and up, commands stay below
        for (b = 0; b < `TBL_BANKS; b++) begin
            addEntry("cpuWrite", kindCpuWr, b, 52, randWord());
            addEntry("cpuReadBack", kindCpuRd, b, 52, '0);
            addEntry("cpuReadFill", kindCpuRd, b, 60, '0);
        end
        // cpu write held off by a command run to its bank
        addEntry("cpuStall", kindCpuWr, 1, 50, randWord());
        for (e = 0; e < 6; e++) begin
            addEntry("stallRun", kindCmdWr, 1, 20 + e, randWord());
        end
        addEntry("cpuStillPending", kindPend, 1, 50, '0);
        addEntry("cpuStallRead", kindCpuRd, 1, 50, '0);
        addEntry("stallRunRead", kindCmdRd, 1, 22, '0);
        // traffic on bank 3 leaves bank 2 free
        addEntry("cpuOtherBank", kindCpuWr, 2, 51, randWord());
        for (e = 0; e < 6; e++) begin
            addEntry("otherRun", kindCmdRd, 3, 30 + e, '0);
        end
        addEntry("cpuNotDelayed", kindDone, 2, 51, '0);
        // random mix, mostly commands
        for (int n = 0; n < 80; n++) begin
            r = int'($urandom % 8);
            b = int'($urandom % `TBL_BANKS);
            if (r < 3) begin
                addEntry("randCmdRd", kindCmdRd, b, int'($urandom % 48), '0);
            end else if (r < 6) begin
                addEntry("randCmdWr", kindCmdWr, b, int'($urandom % 48), randWord());
            end else if (r == 6) begin
                addEntry("randCpuRd", kindCpuRd, b, 48 + int'($urandom % 16), '0);
            end else begin
                addEntry("randCpuWr", kindCpuWr, b, 48 + int'($urandom % 16), randWord());
            end
        end
    endtask

    // writes in issue order, read followed at once by a write takes its data
    task automatic buildExpect();
        for (int i = 0; i < nEntries; i++) begin
            tExpect[i] = model[tAddr[i]];
            case (tKind[i])
                kindCmdWr, kindCpuWr: model[tAddr[i]] = tData[i];
                kindPair: begin
                    tExpect[i]      = tData[i];
                    model[tAddr[i]] = tData[i];
                end
                kindCmdRd: begin
                    if (i + 1 < nEntries && tKind[i + 1] == kindCmdWr
                        && tAddr[i + 1] == tAddr[i]) begin
                        tExpect[i] = tData[i + 1];
                    end
                end
                default: ;
            endcase
        end
    endtask

    // ======================================================================
    // drivers
    // ======================================================================
    // one clock, command strobe falls, cpu drops its request after the ack
    task automatic stepCycle();
        @(posedge clockCore);
        cmdReq <= 1'b0;
        if (cpuReq && cpuStarts == cpuAcks) begin
            cpuReq <= 1'b0;
        end
    endtask

    // a second drive in the same cycle would overwrite the first command
    task automatic driveCmd(input int i, input bit isRd);
        assert (!cmdDriven || cmdDriveTime != $time) else begin
            seqErrors++;
            $display("command %s driven in a cycle that already carries a command",
                     tName[i]);
        end
        cmdDriven    = 1'b1;
        cmdDriveTime = $time;
        cmdReq    <= 1'b1;
        cmdRd     <= isRd;
        cmdAddr   <= tAddr[i];
        cmdWrData <= tData[i];
        if (isRd) begin
            expName[nIssued] = tName[i];
            expData[nIssued] = tExpect[i];
            expTime[nIssued] = $time;
            nIssued++;
        end
    endtask

    // wait for the port to go idle with the request low for a cycle
    task automatic driveCpu(input int i, input bit isRd);
        while (cpuReq || cpuStarts != cpuAcks) begin
            stepCycle();
        end
        cpuName    = tName[i];
        cpuExpRd   = isRd;
        cpuExpData = tExpect[i];
        cpuReq    <= 1'b1;
        cpuRd     <= isRd;
        cpuAddr   <= tAddr[i];
        cpuWrData <= tData[i];
        cpuStarts++;
    endtask

    // ======================================================================
    // result checks, mid-cycle
    // ======================================================================
    always @(negedge clockCore) begin
        if (cmdRdValid) begin
            assert (nChecked < nIssued) else begin
                cmdErrors++;
                $display("cmdRdValid pulsed with no command read outstanding");
            end
            if (nChecked < nIssued) begin
                cmdLatency = ($time - expTime[nChecked]) / 20;
                assert (cmdRdData == expData[nChecked]) else begin
                    cmdErrors++;
                    $display("Error %s: expected %h, actual %h", expName[nChecked],
                             expData[nChecked], cmdRdData);
                end
                assert (cmdLatency == 4) else begin
                    cmdErrors++;
                    $display("Error %s latency: expected 4, actual %0d", expName[nChecked],
                             cmdLatency);
                end
                nChecked++;
            end
        end
    end

    always @(negedge clockCore) begin
        if (cpuAck) begin
            assert (cpuStarts != cpuAcks) else begin
                cpuErrors++;
                $display("cpuAck pulsed with no cpu request outstanding");
            end
            assert (!ackLast) else begin
                cpuErrors++;
                $display("cpuAck stayed high for more than one cycle");
            end
            if (cpuStarts != cpuAcks) begin
                if (cpuExpRd) begin
                    assert (cpuRdData == cpuExpData) else begin
                        cpuErrors++;
                        $display("Error %s: expected %h, actual %h", cpuName, cpuExpData,
                                 cpuRdData);
                    end
                end
                cpuAcks++;
            end
        end
        ackLast = cpuAck;
    end

    // ======================================================================
    // main sequence
    // ======================================================================
    initial begin
        resetCore  = 1'b0;
        cmdReq     = 1'b0;
        cmdRd      = 1'b0;
        cmdAddr    = '0;
        cmdWrData  = '0;
        cpuReq     = 1'b0;
        cpuRd      = 1'b0;
        cpuAddr    = '0;
        cpuWrData  = '0;
        cpuExpRd   = 1'b0;
        cpuExpData = '0;
        cpuStarts  = 0;
        nIssued    = 0;
        nEntries   = 0;
        seqErrors  = 0;
        void'($urandom(32'h27f4_3d15));
        buildTable();
        buildExpect();
        cycleLimit = nEntries * 10 + 100;

        repeat (5) @(posedge clockCore);
        resetCore <= 1'b1;

        for (int i = 0; i < nEntries; i++) begin
            stepCycle();
            case (tKind[i])
                kindCmdRd: driveCmd(i, 1'b1);
                kindCmdWr: driveCmd(i, 1'b0);
                kindPair: begin
                    driveCmd(i, 1'b1);
                    stepCycle();
                    driveCmd(i, 1'b0);
                end
                kindCpuRd: driveCpu(i, 1'b1);
                kindCpuWr: driveCpu(i, 1'b0);
                kindPend: begin
                    assert (cpuStarts != cpuAcks) else begin
                        seqErrors++;
                        $display("%s: cpu request finished during commands to its bank",
                                 tName[i]);
                    end
                end
                kindDone: begin
                    assert (cpuStarts == cpuAcks) else begin
                        seqErrors++;
                        $display("%s: cpu request held up by commands to another bank",
                                 tName[i]);
                    end
                end
                default: ;
            endcase
        end

        // drain outstanding results, then watch for stray pulses
        while (nChecked < nIssued || cpuReq || cpuStarts != cpuAcks) begin
            stepCycle();
        end
        repeat (10) stepCycle();

        $display("errors: command %0d, cpu %0d, sequence %0d", cmdErrors, cpuErrors, seqErrors);
        if (cmdErrors + cpuErrors + seqErrors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule
